/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_opn_top
FILELIST   := all.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+design
design/opn_reg_pkg.sv
design/opn_snd_pkg.sv
design/opn_clk_gen.sv
design/opn_bus_port.sv
design/opn_timer.sv
design/opn_mixer.sv
design/opn_top.sv
bench/opn_checker.sv
bench/tb_opn_top.sv

/* bench/opn_checker.sv */
// ==============================
// OPN bus port assertions
// irq_n, status byte and busy
// length, bound into the port
// ==============================
`timescale 1ns/1ns
`include "opn_defines.svh"

module opn_checker (
    input logic       clk,
    input logic       rst_n,
    input logic       busy,
    input logic       flag_a,
    input logic       flag_b,
    input logic [7:0] dout,
    input logic       irq_n
);

    int         assert_errors = 0;
    logic [7:0] busy_len;   // Cycles busy has been high, saturating

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            busy_len <= '0;
        else if (!busy)
            busy_len <= '0;
        else if (busy_len != 8'hFF)
            busy_len <= busy_len + 1'b1;
    end

    irq_follows_flags: assert property (@(posedge clk) disable iff (!rst_n)
        irq_n == !($past(flag_a) || $past(flag_b)))
        else begin
            $error("irq_n does not match the timer flags");
            assert_errors++;
        end

    flags_in_dout: assert property (@(posedge clk) disable iff (!rst_n)
        dout[1:0] == {$past(flag_b), $past(flag_a)})
        else begin
            $error("dout flag bits do not match the timer flags");
            assert_errors++;
        end

    busy_in_dout: assert property (@(posedge clk) disable iff (!rst_n)
        dout[7] == $past(busy))
        else begin
            $error("dout bit 7 does not follow busy");
            assert_errors++;
        end

    busy_min_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> busy_len >= 8'(`OPN_BUSY_CYCLES))
        else begin
            $error("busy fell after only %0d cycles", $sampled(busy_len));
            assert_errors++;
        end

endmodule

bind opn_bus_port opn_checker u_checker (
    .clk    ( clk    ),
    .rst_n  ( rst_n  ),
    .busy   ( busy   ),
    .flag_a ( flag_a ),
    .flag_b ( flag_b ),
    .dout   ( dout   ),
    .irq_n  ( irq_n  )
);

/* bench/tb_opn_top.sv */
// ==============================
// OPN control core testbench
// Table of register writes with
// status checks, then mixer cases
// ==============================
`timescale 1ns/1ns
`include "opn_defines.svh"

module tb_opn_top import opn_snd_pkg::*; ();

    localparam int CLK_HALF     = 50;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 16;
    localparam int BUSY_BOUND   = 40;   // Busy must clear within this many cycles
    localparam int NUM_STEPS    = 10;
    localparam int MIX_CASES    = 8;
    localparam int MIX_BOUND    = 160;  // One sample period is 144 clk
    localparam int MARGIN       = 200;

    // One table row, status is {irq_n, dout}
    typedef struct packed {
        logic [7:0] reg_num;
        logic [7:0] data;
        logic [7:0] bound;  // Cycles allowed after busy clears
        logic [8:0] mask;
        logic [8:0] value;
        logic       hold;   // Value must hold for the whole bound
    } step_t;

    step_t steps [NUM_STEPS] = '{
        '{`OPN_REG_TEST,  8'h04, 8'd10, 9'h183, 9'h100, 1'b0},
        '{`OPN_REG_TA_HI, 8'hFF, 8'd10, 9'h183, 9'h100, 1'b0},
        '{`OPN_REG_TA_LO, 8'h00, 8'd10, 9'h183, 9'h100, 1'b0},
        '{`OPN_REG_CTRL,  8'h05, 8'd10, 9'h101, 9'h001, 1'b0},
        '{`OPN_REG_CTRL,  8'h10, 8'd10, 9'h103, 9'h100, 1'b0},
        '{`OPN_REG_TB,    8'hFE, 8'd10, 9'h103, 9'h100, 1'b0},
        '{`OPN_REG_CTRL,  8'h0A, 8'd40, 9'h102, 9'h002, 1'b0},
        '{`OPN_REG_CTRL,  8'h20, 8'd10, 9'h103, 9'h100, 1'b0},
        '{8'h30,          8'hFF, 8'd10, 9'h183, 9'h100, 1'b0},
        '{`OPN_REG_CTRL,  8'h01, 8'd20, 9'h101, 9'h100, 1'b1}
    };

    string step_names [NUM_STEPS] = '{
        "fast timers on", "timer A high bits", "timer A low bits", "timer A flag",
        "timer A clear", "timer B value", "timer B flag", "timer B clear",
        "unknown register", "timer A without flag enable"
    };

    logic [3:0] enable_patterns [4] = '{4'b0000, 4'b0001, 4'b1000, 4'b1001};

    logic       clk;
    logic       rst_n;
    logic       cs_n;
    logic       wr_n;
    logic [1:0] addr;
    logic [7:0] din;
    logic [7:0] dout;
    logic       irq_n;
    logic [3:0] snd_enable;
    stereo_t    fm_snd;
    psg_t       psg_snd;
    stereo_t    snd;
    logic       snd_sample;
    logic [8:0] status_now;

    int          errors = 0;
    int          checks = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    logic [31:0] lcg_state;

    assign status_now = {irq_n, dout};

    opn_top dut (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cs_n       ( cs_n       ),
        .wr_n       ( wr_n       ),
        .addr       ( addr       ),
        .din        ( din        ),
        .dout       ( dout       ),
        .irq_n      ( irq_n      ),
        .snd_enable ( snd_enable ),
        .fm_snd     ( fm_snd     ),
        .psg_snd    ( psg_snd    ),
        .snd        ( snd        ),
        .snd_sample ( snd_sample )
    );

    always #CLK_HALF clk = ~clk;

    // Watchdog on the whole run
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // FM gated by bit 0, PSG level times 16 added under bit 3
    function automatic logic [15:0] mix_expect(input logic [3:0] en, input logic [15:0] fm,
                                               input logic [9:0] psg);
        logic [15:0] fm_part;
        logic [15:0] psg_part;
        fm_part  = en[0] ? fm : 16'h0000;
        psg_part = en[3] ? (16'(psg) << 4) : 16'h0000;
        return fm_part + psg_part;  // Wraps at 16 bits
    endfunction

    function automatic int run_length();
        int total;
        total = RESET_CYCLES + 4 + MIX_CASES * (MIX_BOUND + 1) + MARGIN;
        for (int i = 0; i < NUM_STEPS; i++)
            total += int'(steps[i].bound) + BUSY_BOUND + 4;
        return total;
    endfunction

    task automatic next_edge();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic finish_test(input int num, input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed", num, name);
        end
    endtask

    // Address write, data write, then wait out busy
    task automatic write_reg(input logic [7:0] reg_num, input logic [7:0] data);
        int n;
        cs_n = 1'b0;
        wr_n = 1'b0;
        addr = 2'b00;
        din  = reg_num;
        next_edge();
        addr = 2'b01;
        din  = data;
        next_edge();
        cs_n = 1'b1;
        wr_n = 1'b1;
        next_edge();
        check_value("dout[7]", 32'(dout[7]), 32'd1);
        n = 0;
        while (dout[7] && n < BUSY_BOUND) begin
            next_edge();
            n++;
        end
        if (dout[7]) begin
            $display("Busy still set %0d cycles after writing register 0x%02h",
                     BUSY_BOUND, reg_num);
            errors++;
        end
    endtask

    task automatic run_step(input int idx);
        int n;
        write_reg(steps[idx].reg_num, steps[idx].data);
        if (steps[idx].hold) begin
            for (n = 0; n < int'(steps[idx].bound); n++) begin
                check_value("status {irq_n,dout}", 32'(status_now & steps[idx].mask),
                            32'(steps[idx].value));
                next_edge();
            end
        end else begin
            n = 0;
            while ((status_now & steps[idx].mask) != steps[idx].value &&
                   n < int'(steps[idx].bound)) begin
                next_edge();
                n++;
            end
            if ((status_now & steps[idx].mask) != steps[idx].value)
                $display("Status not reached within %0d cycles after register 0x%02h",
                         steps[idx].bound, steps[idx].reg_num);
            check_value("status {irq_n,dout}", 32'(status_now & steps[idx].mask),
                        32'(steps[idx].value));
        end
    endtask

    task automatic run_mix_case(input logic [3:0] en);
        int          n;
        logic [15:0] exp_left;
        logic [15:0] exp_right;
        lcg_state = lcg_next(lcg_state);
        fm_snd.left = lcg_state[31:16];
        lcg_state = lcg_next(lcg_state);
        fm_snd.right = lcg_state[31:16];
        lcg_state = lcg_next(lcg_state);
        psg_snd = lcg_state[25:16];
        snd_enable = en;
        exp_left  = mix_expect(en, fm_snd.left, psg_snd);
        exp_right = mix_expect(en, fm_snd.right, psg_snd);
        n = 0;
        do begin
            next_edge();
            n++;
        end while (!snd_sample && n < MIX_BOUND);
        if (!snd_sample) begin
            $display("No sample strobe within %0d cycles", MIX_BOUND);
            errors++;
        end else begin
            check_value("snd.left", {16'h0000, snd.left}, {16'h0000, exp_left});
            check_value("snd.right", {16'h0000, snd.right}, {16'h0000, exp_right});
        end
    endtask

    initial begin
        int errors_before;
        clk        = 1'b0;
        rst_n      = 1'b0;
        cs_n       = 1'b1;
        wr_n       = 1'b1;
        addr       = 2'b00;
        din        = 8'h00;
        snd_enable = 4'h0;
        fm_snd     = '0;
        psg_snd    = '0;
        lcg_state  = 32'd62704;
        cycle_limit = run_length();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b1;
        next_edge();

        errors_before = errors;
        check_value("dout", 32'(dout), 32'h00);
        check_value("irq_n", 32'(irq_n), 32'd1);
        check_value("snd", snd, 32'h0);
        check_value("snd_sample", 32'(snd_sample), 32'd0);
        finish_test(0, "reset state", errors_before);

        for (int i = 0; i < NUM_STEPS; i++) begin
            errors_before = errors;
            run_step(i);
            finish_test(i + 1, step_names[i], errors_before);
        end

        for (int i = 0; i < MIX_CASES; i++) begin
            errors_before = errors;
            run_mix_case(enable_patterns[i % 4]);
            finish_test(NUM_STEPS + 1 + i, "mixer", errors_before);
        end

        errors += dut.u_bus_port.u_checker.assert_errors;
        $display("%0d tests passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* design/opn_bus_port.sv */
// ==============================
// OPN CPU bus port
// Address latch, register decode,
// busy counter, status and irq_n
// ==============================
`timescale 1ns/1ns
`include "opn_defines.svh"

module opn_bus_port import opn_reg_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cs_n,
    input  logic       wr_n,
    input  logic [1:0] addr,
    input  logic [7:0] din,
    input  logic       flag_a,
    input  logic       flag_b,
    output logic [7:0] dout,
    output logic       irq_n,
    output ta_value_t  ta_value,
    output tb_value_t  tb_value,
    output timer_ctl_t ta_ctl,
    output timer_ctl_t tb_ctl,
    output logic       fast_timers
);

    localparam int BUSY_W = $clog2(`OPN_BUSY_CYCLES);

    bus_wr_t           wr;
    status_t           status;
    logic [7:0]        reg_sel;     // Latched register number
    logic              busy;
    logic [BUSY_W-1:0] busy_cnt;

    // addr[1] selects the part-II bank on the full chip, ignored here
    assign wr = '{
        addr_wr: !cs_n && !wr_n && !addr[0],
        data_wr: !cs_n && !wr_n &&  addr[0],
        data:    din
    };

    assign status = '{flag_a: flag_a, flag_b: flag_b, busy: busy};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_sel     <= '0;
            ta_value    <= '0;
            tb_value    <= '0;
            ta_ctl      <= '0;
            tb_ctl      <= '0;
            fast_timers <= 1'b0;
        end else begin
            ta_ctl.clr <= 1'b0;     // Clears last a single cycle
            tb_ctl.clr <= 1'b0;
            if (wr.addr_wr)
                reg_sel <= wr.data;
            if (wr.data_wr) begin
                case (reg_sel)
                    `OPN_REG_TEST:  fast_timers    <= wr.data[`OPN_TEST_FAST];
                    `OPN_REG_TA_HI: ta_value[9:2] <= wr.data;
                    `OPN_REG_TA_LO: ta_value[1:0] <= wr.data[1:0];
                    `OPN_REG_TB:    tb_value      <= wr.data;
                    `OPN_REG_CTRL: begin
                        ta_ctl.load    <= wr.data[`OPN_CTL_LOAD_A];
                        tb_ctl.load    <= wr.data[`OPN_CTL_LOAD_B];
                        ta_ctl.flag_en <= wr.data[`OPN_CTL_EN_A];
                        tb_ctl.flag_en <= wr.data[`OPN_CTL_EN_B];
                        ta_ctl.clr     <= wr.data[`OPN_CTL_CLR_A];
                        tb_ctl.clr     <= wr.data[`OPN_CTL_CLR_B];
                    end
                    default: ;      // Unknown register, write dropped
                endcase
            end
        end
    end

    // Busy holds for 32 clk after each data write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (wr.data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= BUSY_W'(`OPN_BUSY_CYCLES - 1);
        end else if (busy) begin
            if (busy_cnt == '0)
                busy <= 1'b0;
            else
                busy_cnt <= busy_cnt - 1'b1;
        end
    end

    // Status byte and interrupt, registered together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout  <= 8'h00;
            irq_n <= 1'b1;
        end else begin
            dout  <= {status.busy, 5'b00000, status.flag_b, status.flag_a};
            irq_n <= ~(status.flag_a | status.flag_b);
        end
    end

endmodule

/* design/opn_clk_gen.sv */
// ==============================
// OPN prescaler
// Makes clk_en, the sample strobe
// and the two timer ticks
// ==============================
`timescale 1ns/1ns
`include "opn_defines.svh"

module opn_clk_gen import opn_snd_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  fast_timers,
    output tick_t tick
);

    localparam int CEN_W  = $clog2(`OPN_CEN_DIV);
    localparam int SLOT_W = $clog2(`OPN_SLOTS);
    localparam int TB_W   = $clog2(`OPN_TB_DIV);

    logic [CEN_W-1:0]  cen_cnt;
    logic [SLOT_W-1:0] slot_cnt;
    logic [TB_W-1:0]   tb_cnt;
    logic              cen_nxt;
    logic              zero_nxt;
    logic              ta_nxt;
    logic              tb_nxt;

    assign cen_nxt  = (cen_cnt == CEN_W'(`OPN_CEN_DIV - 1));
    assign zero_nxt = cen_nxt && (slot_cnt == SLOT_W'(`OPN_SLOTS - 1));
    assign ta_nxt   = fast_timers | zero_nxt;   // Test mode counts every clk
    assign tb_nxt   = ta_nxt && (tb_cnt == TB_W'(`OPN_TB_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_cnt  <= '0;
            slot_cnt <= '0;
            tb_cnt   <= '0;
            tick     <= '0;
        end else begin
            cen_cnt <= cen_nxt ? '0 : cen_cnt + 1'b1;
            if (cen_nxt)
                slot_cnt <= zero_nxt ? '0 : slot_cnt + 1'b1;
            if (ta_nxt)
                tb_cnt <= tb_cnt + 1'b1;    // Wraps at 16
            tick <= '{clk_en: cen_nxt, zero: zero_nxt, tick_a: ta_nxt, tick_b: tb_nxt};
        end
    end

endmodule

/* design/opn_defines.svh */
// ==============================
// OPN control core constants
// Register numbers, control bits,
// prescaler ratios, busy length
// ==============================
`ifndef OPN_DEFINES_SVH
`define OPN_DEFINES_SVH

// Register numbers
`define OPN_REG_TEST    8'h21
`define OPN_REG_TA_HI   8'h24   // Timer A bits 9..2
`define OPN_REG_TA_LO   8'h25   // Timer A bits 1..0
`define OPN_REG_TB      8'h26
`define OPN_REG_CTRL    8'h27

// Bit positions in register 0x27
`define OPN_CTL_LOAD_A  0
`define OPN_CTL_LOAD_B  1
`define OPN_CTL_EN_A    2
`define OPN_CTL_EN_B    3
`define OPN_CTL_CLR_A   4
`define OPN_CTL_CLR_B   5

`define OPN_TEST_FAST   2       // Bit in register 0x21

// Clock ratios
`define OPN_CEN_DIV     6       // clk per clk_en
`define OPN_SLOTS       24      // clk_en per sample
`define OPN_TB_DIV      16      // Timer A ticks per timer B tick
`define OPN_BUSY_CYCLES 32

`endif

/* design/opn_mixer.sv */
// ==============================
// OPN output mixer
// Gated FM plus shifted PSG level,
// registered on the sample strobe
// ==============================
`timescale 1ns/1ns

module opn_mixer import opn_snd_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       zero,
    input  logic [3:0] snd_enable,  // Bits 1 and 2 gate ADPCM on the full chip
    input  stereo_t    fm_snd,
    input  psg_t       psg_snd,
    output stereo_t    snd,
    output logic       snd_sample
);

    stereo_t fm_gated;
    sample_t psg_ext;
    stereo_t mix;

    assign fm_gated = snd_enable[0] ? fm_snd : '0;

    // PSG sits four bits up, always positive
    assign psg_ext = snd_enable[3] ? {2'b00, psg_snd, 4'h0} : '0;

    // 16-bit sums, overflow wraps
    assign mix.left  = fm_gated.left  + psg_ext;
    assign mix.right = fm_gated.right + psg_ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd        <= '0;
            snd_sample <= 1'b0;
        end else begin
            if (zero)
                snd <= mix;
            snd_sample <= zero;     // High while the new sample is on snd
        end
    end

endmodule

/* design/opn_reg_pkg.sv */
// ==============================
// OPN register port types
// Write strobes, timer control,
// status bits and timer values
// ==============================
package opn_reg_pkg;

    // One CPU bus cycle, decoded
    typedef struct packed {
        logic       addr_wr;    // Register number write
        logic       data_wr;    // Data write to latched register
        logic [7:0] data;
    } bus_wr_t;

    // Control for one timer
    typedef struct packed {
        logic load;     // Counter runs while high
        logic flag_en;  // Overflow may set the flag
        logic clr;      // One-cycle flag clear
    } timer_ctl_t;

    // Status as read back by the CPU
    typedef struct packed {
        logic flag_a;
        logic flag_b;
        logic busy;
    } status_t;

    // Timer A is 10 bits wide
    typedef logic [9:0] ta_value_t;

    // Timer B is 8 bits wide
    typedef logic [7:0] tb_value_t;

endpackage

/* design/opn_snd_pkg.sv */
// ==============================
// OPN sound side types
// Samples and prescaler ticks
// ==============================
package opn_snd_pkg;

    typedef logic signed [15:0] sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    typedef logic [9:0] psg_t;  // Unsigned PSG level

    // Prescaler outputs, one clk wide each
    typedef struct packed {
        logic clk_en;   // One clk in six
        logic zero;     // Sample strobe
        logic tick_a;   // Timer A count
        logic tick_b;   // Timer B count
    } tick_t;

endpackage

/* design/opn_timer.sv */
// ==============================
// OPN timer
// Loadable up-counter with an
// overflow flag, width set by type
// ==============================
`timescale 1ns/1ns

module opn_timer import opn_reg_pkg::*; #(
    parameter type cnt_t = logic [7:0]
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tick,
    input  cnt_t       value,
    input  timer_ctl_t ctl,
    output logic       flag
);

    cnt_t cnt;
    logic load_d;
    logic load_rise;
    logic overflow;

    assign load_rise = ctl.load & ~load_d;
    assign overflow  = ctl.load && !load_rise && tick && (cnt == '1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            load_d <= 1'b0;
        end else begin
            load_d <= ctl.load;
            if (load_rise)
                cnt <= value;               // Start from the programmed value
            else if (ctl.load && tick)
                cnt <= overflow ? value : cnt_t'(cnt + 1'b1);
        end
    end

    // Clear has priority over a new overflow
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            flag <= 1'b0;
        else if (ctl.clr)
            flag <= 1'b0;
        else if (overflow && ctl.flag_en)
            flag <= 1'b1;
    end

endmodule

/* design/opn_top.sv */
// ==============================
// OPN control core top level
// Bus port, prescaler, timers A
// and B, and the output mixer
// ==============================
`timescale 1ns/1ns

module opn_top
    import opn_reg_pkg::*;
    import opn_snd_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // CPU bus
    input  logic       cs_n,
    input  logic       wr_n,
    input  logic [1:0] addr,
    input  logic [7:0] din,
    output logic [7:0] dout,
    output logic       irq_n,
    // Sound
    input  logic [3:0] snd_enable,
    input  stereo_t    fm_snd,      // From an external FM engine
    input  psg_t       psg_snd,
    output stereo_t    snd,
    output logic       snd_sample
);

    tick_t      tick;
    timer_ctl_t ta_ctl;
    timer_ctl_t tb_ctl;
    ta_value_t  ta_value;
    tb_value_t  tb_value;
    logic       flag_a;
    logic       flag_b;
    logic       fast_timers;

    opn_bus_port u_bus_port (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .cs_n        ( cs_n        ),
        .wr_n        ( wr_n        ),
        .addr        ( addr        ),
        .din         ( din         ),
        .flag_a      ( flag_a      ),
        .flag_b      ( flag_b      ),
        .dout        ( dout        ),
        .irq_n       ( irq_n       ),
        .ta_value    ( ta_value    ),
        .tb_value    ( tb_value    ),
        .ta_ctl      ( ta_ctl      ),
        .tb_ctl      ( tb_ctl      ),
        .fast_timers ( fast_timers )
    );

    opn_clk_gen u_clk_gen (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .fast_timers ( fast_timers ),
        .tick        ( tick        )
    );

    opn_timer #(.cnt_t(ta_value_t)) u_timer_a (
        .clk   ( clk         ),
        .rst_n ( rst_n       ),
        .tick  ( tick.tick_a ),
        .value ( ta_value    ),
        .ctl   ( ta_ctl      ),
        .flag  ( flag_a      )
    );

    opn_timer #(.cnt_t(tb_value_t)) u_timer_b (
        .clk   ( clk         ),
        .rst_n ( rst_n       ),
        .tick  ( tick.tick_b ),
        .value ( tb_value    ),
        .ctl   ( tb_ctl      ),
        .flag  ( flag_b      )
    );

    opn_mixer u_mixer (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .zero       ( tick.zero  ),
        .snd_enable ( snd_enable ),
        .fm_snd     ( fm_snd     ),
        .psg_snd    ( psg_snd    ),
        .snd        ( snd        ),
        .snd_sample ( snd_sample )
    );

endmodule
